/* hw/credit_pkg.sv */
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit link definitions
// Word and port widths, credit and queue depths, and the
// last-grant state of the link arbiter, shared by every
// block of the two-port credit-flow link
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package credit_pkg;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Link geometry
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int DATA_W  = 16;
   localparam int N_PORTS = 2;
   localparam int PORT_W  = $clog2(N_PORTS);                // Port number carried on the link

   localparam logic [PORT_W-1:0] PORT_A = PORT_W'(0);
   localparam logic [PORT_W-1:0] PORT_B = PORT_W'(1);

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Credits and queues
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int MAX_CREDITS = 4;                         // Also the receive buffer depth
   localparam int CNT_W       = $clog2(MAX_CREDITS + 1);   // Holds 0 to MAX_CREDITS
   localparam int RX_PTR_W    = $clog2(MAX_CREDITS);

   localparam int SEND_DEPTH  = 2;
   localparam int SEND_PTR_W  = $clog2(SEND_DEPTH);
   localparam int SEND_CNT_W  = $clog2(SEND_DEPTH + 1);

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Arbiter state
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic {
      grant_a,                                             // Port A won last
      grant_b                                              // Port B won last
   } grant_e;

endpackage

`default_nettype wire

/* hw/credit_manager.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit manager
// Counts credits issued to one sender against a software
// limit. Returns from the receive buffer free credits in
// the cycle they arrive. Over-use and over-return raise
// sticky error flags that software may mask
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module credit_manager (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            sw_init,
   input  logic                            credit_used,
   input  logic                            credit_return,
   input  logic [credit_pkg::CNT_W-1:0]    credit_limit,
   input  logic                            dis_used,
   input  logic                            dis_return,
   output logic                            credit_available,
   output logic                            used_err,
   output logic                            return_err,
   output logic [credit_pkg::CNT_W-1:0]    credit_issued
);

   typedef logic [credit_pkg::CNT_W-1:0] cnt_t;
   typedef logic [credit_pkg::CNT_W:0]   sum_t;

   cnt_t issued_q;
   cnt_t issued_v;
   cnt_t issued_next;
   sum_t sum_v;
   logic used_err_v;
   logic return_err_v;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Next issued count
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      return_err_v = 1'b0;
      issued_v     = issued_q;
      if (credit_return) begin
         if (issued_q == '0) begin
            return_err_v = 1'b1;                           // Nothing was out to give back
         end else begin
            issued_v = issued_q - cnt_t'(1);
         end
      end

      // The return of this cycle already counts toward availability
      credit_available = (credit_limit > issued_v);

      // A lowered limit flags even without a use in this cycle
      sum_v      = sum_t'(issued_v) + sum_t'(credit_used);
      used_err_v = (sum_v > sum_t'(credit_limit));

      if (used_err_v) begin
         issued_next = credit_limit;                       // Clamp at the limit
      end else begin
         issued_next = cnt_t'(sum_v);
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // State and sticky status
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issued_q   <= '0;
         used_err   <= 1'b0;
         return_err <= 1'b0;
      end else if (sw_init) begin
         issued_q   <= '0;                                 // Same as reset for this port only
         used_err   <= 1'b0;
         return_err <= 1'b0;
      end else begin
         issued_q   <= issued_next;
         used_err   <= !dis_used && (used_err || used_err_v);
         return_err <= !dis_return && (return_err || return_err_v);
      end
   end

   assign credit_issued = issued_q;

endmodule

`default_nettype wire

/* hw/credit_sender.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit-gated sender
// Small input FIFO for one port. The head word requests
// the shared link only while a credit is available and
// leaves the queue when the arbiter grants it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module credit_sender (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             in_valid,
   input  logic [credit_pkg::DATA_W-1:0]    in_data,
   output logic                             in_ready,
   input  logic                             credit_available,
   input  logic                             send_grant,
   output logic                             send_req,
   output logic [credit_pkg::DATA_W-1:0]    send_data
);

   typedef logic [credit_pkg::SEND_PTR_W-1:0] ptr_t;
   typedef logic [credit_pkg::SEND_CNT_W-1:0] cnt_t;

   logic [credit_pkg::DATA_W-1:0] mem [credit_pkg::SEND_DEPTH];

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;
   logic push;
   logic pop;

   assign in_ready  = (count != cnt_t'(credit_pkg::SEND_DEPTH));
   assign push      = in_valid && in_ready;
   assign pop       = send_grant;                          // Grant only follows a request

   assign send_req  = (count != '0) && credit_available;
   assign send_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Pointers and fill level
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
         case ({push, pop})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count;                       // Idle, or accept and send together
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/link_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link arbiter
// Round-robin grant of the shared link between the two
// senders. The winning word and its port number are
// registered onto the link, which has no ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module link_arbiter (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             send_req_a,
   input  logic [credit_pkg::DATA_W-1:0]    send_data_a,
   input  logic                             send_req_b,
   input  logic [credit_pkg::DATA_W-1:0]    send_data_b,
   output logic                             send_grant_a,
   output logic                             send_grant_b,
   output logic                             link_valid,
   output logic [credit_pkg::PORT_W-1:0]    link_port,
   output logic [credit_pkg::DATA_W-1:0]    link_data
);

   logic [credit_pkg::N_PORTS-1:0] req;
   logic [credit_pkg::N_PORTS-1:0] grant;
   credit_pkg::grant_e             last_q;

   assign req = {send_req_b, send_req_a};

   always_comb begin
      grant = req;
      if (&req) begin
         grant = (last_q == credit_pkg::grant_a) ? 2'b10 : 2'b01;   // The other port wins a tie
      end
   end

   assign send_grant_a = grant[0];
   assign send_grant_b = grant[1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_q     <= credit_pkg::grant_b;                // Port A wins the first tie
         link_valid <= 1'b0;
      end else begin
         link_valid <= |grant;
         if (|grant) begin
            last_q <= grant[1] ? credit_pkg::grant_b : credit_pkg::grant_a;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (|grant) begin
         link_port <= grant[1] ? credit_pkg::PORT_B : credit_pkg::PORT_A;
         link_data <= grant[1] ? send_data_b : send_data_a;
      end
   end

endmodule

`default_nettype wire

/* hw/rx_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive buffer
// Queue of credit depth on the far side of the link for
// one port. Catches link words addressed to that port,
// drains them to a valid/ready output and hands back one
// credit for every word popped
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module rx_buffer (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [credit_pkg::PORT_W-1:0]    port_id,
   input  logic                             link_valid,
   input  logic [credit_pkg::PORT_W-1:0]    link_port,
   input  logic [credit_pkg::DATA_W-1:0]    link_data,
   output logic                             out_valid,
   output logic [credit_pkg::DATA_W-1:0]    out_data,
   input  logic                             out_ready,
   output logic                             credit_return
);

   typedef logic [credit_pkg::RX_PTR_W-1:0] ptr_t;
   typedef logic [credit_pkg::CNT_W-1:0]    cnt_t;

   logic [credit_pkg::DATA_W-1:0] mem [credit_pkg::MAX_CREDITS];

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;
   logic wr_en;
   logic pop;

   // The credit spent by the sender guarantees a free entry
   assign wr_en     = link_valid && (link_port == port_id);

   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= link_data;
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Pointers, fill level and credit return
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
         case ({wr_en, pop})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count;
         endcase
         credit_return <= pop;                             // One credit back per word popped
      end
   end

endmodule

`default_nettype wire

/* hw/credit_link_top.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-port credit link
// Two credit-gated senders share one registered link
// through a round-robin arbiter. Each port has its own
// receive buffer and credit manager
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module credit_link_top (
   input  logic                             clk,
   input  logic                             rst_n,
   // Port A
   input  logic                             in_a_valid,
   output logic                             in_a_ready,
   input  logic [credit_pkg::DATA_W-1:0]    in_a_data,
   output logic                             out_a_valid,
   input  logic                             out_a_ready,
   output logic [credit_pkg::DATA_W-1:0]    out_a_data,
   input  logic                             sw_init_a,
   input  logic                             dis_used_a,
   input  logic                             dis_return_a,
   input  logic [credit_pkg::CNT_W-1:0]     credit_limit_a,
   output logic                             used_err_a,
   output logic                             return_err_a,
   output logic [credit_pkg::CNT_W-1:0]     credit_issued_a,
   // Port B
   input  logic                             in_b_valid,
   output logic                             in_b_ready,
   input  logic [credit_pkg::DATA_W-1:0]    in_b_data,
   output logic                             out_b_valid,
   input  logic                             out_b_ready,
   output logic [credit_pkg::DATA_W-1:0]    out_b_data,
   input  logic                             sw_init_b,
   input  logic                             dis_used_b,
   input  logic                             dis_return_b,
   input  logic [credit_pkg::CNT_W-1:0]     credit_limit_b,
   output logic                             used_err_b,
   output logic                             return_err_b,
   output logic [credit_pkg::CNT_W-1:0]     credit_issued_b
);

   logic                          send_req_a;
   logic                          send_req_b;
   logic                          send_grant_a;
   logic                          send_grant_b;
   logic [credit_pkg::DATA_W-1:0] send_data_a;
   logic [credit_pkg::DATA_W-1:0] send_data_b;
   logic                          credit_available_a;
   logic                          credit_available_b;
   logic                          credit_return_a;
   logic                          credit_return_b;
   logic                          link_valid;
   logic [credit_pkg::PORT_W-1:0] link_port;
   logic [credit_pkg::DATA_W-1:0] link_data;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Send side
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   credit_sender u_send_a (
      .clk(clk), .rst_n(rst_n),
      .in_valid(in_a_valid), .in_data(in_a_data), .in_ready(in_a_ready),
      .credit_available(credit_available_a), .send_grant(send_grant_a),
      .send_req(send_req_a), .send_data(send_data_a)
   );

   credit_sender u_send_b (
      .clk(clk), .rst_n(rst_n),
      .in_valid(in_b_valid), .in_data(in_b_data), .in_ready(in_b_ready),
      .credit_available(credit_available_b), .send_grant(send_grant_b),
      .send_req(send_req_b), .send_data(send_data_b)
   );

   // A grant is the use of one credit
   credit_manager u_cm_a (
      .clk(clk), .rst_n(rst_n), .sw_init(sw_init_a),
      .credit_used(send_grant_a), .credit_return(credit_return_a),
      .credit_limit(credit_limit_a), .dis_used(dis_used_a), .dis_return(dis_return_a),
      .credit_available(credit_available_a), .used_err(used_err_a),
      .return_err(return_err_a), .credit_issued(credit_issued_a)
   );

   credit_manager u_cm_b (
      .clk(clk), .rst_n(rst_n), .sw_init(sw_init_b),
      .credit_used(send_grant_b), .credit_return(credit_return_b),
      .credit_limit(credit_limit_b), .dis_used(dis_used_b), .dis_return(dis_return_b),
      .credit_available(credit_available_b), .used_err(used_err_b),
      .return_err(return_err_b), .credit_issued(credit_issued_b)
   );

   link_arbiter u_link_arbiter (
      .clk(clk), .rst_n(rst_n),
      .send_req_a(send_req_a), .send_data_a(send_data_a),
      .send_req_b(send_req_b), .send_data_b(send_data_b),
      .send_grant_a(send_grant_a), .send_grant_b(send_grant_b),
      .link_valid(link_valid), .link_port(link_port), .link_data(link_data)
   );

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Receive side
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   rx_buffer u_rx_a (
      .clk(clk), .rst_n(rst_n), .port_id(credit_pkg::PORT_A),
      .link_valid(link_valid), .link_port(link_port), .link_data(link_data),
      .out_valid(out_a_valid), .out_data(out_a_data), .out_ready(out_a_ready),
      .credit_return(credit_return_a)
   );

   rx_buffer u_rx_b (
      .clk(clk), .rst_n(rst_n), .port_id(credit_pkg::PORT_B),
      .link_valid(link_valid), .link_port(link_port), .link_data(link_data),
      .out_valid(out_b_valid), .out_data(out_b_data), .out_ready(out_b_ready),
      .credit_return(credit_return_b)
   );

endmodule

`default_nettype wire

/* verif/credit_link_properties.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit link properties
// Grant exclusivity, grants backed by requests, no write
// into a full receive buffer, and issued credits bounded
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module credit_link_properties (
   input logic                            clk,
   input logic                            rst_n,
   input logic                            req_a,
   input logic                            req_b,
   input logic                            grant_a,
   input logic                            grant_b,
   input logic                            rx_wr_a,
   input logic                            rx_wr_b,
   input logic [credit_pkg::CNT_W-1:0]    rx_count_a,
   input logic [credit_pkg::CNT_W-1:0]    rx_count_b,
   input logic [credit_pkg::CNT_W-1:0]    issued_a,
   input logic [credit_pkg::CNT_W-1:0]    issued_b,
   input logic [credit_pkg::CNT_W-1:0]    limit_a,
   input logic [credit_pkg::CNT_W-1:0]    limit_b
);

   typedef logic [credit_pkg::CNT_W-1:0] cnt_t;

   localparam cnt_t FULL = cnt_t'(credit_pkg::MAX_CREDITS);

   int fail_count;

   grant_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(grant_a && grant_b))
      else begin
         $error("Both ports hold the link grant");
         fail_count++;
      end

   grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      (!grant_a || req_a) && (!grant_b || req_b))
      else begin
         $error("Grant without a request");
         fail_count++;
      end

   no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_wr_a || rx_count_a != FULL) && (!rx_wr_b || rx_count_b != FULL))
      else begin
         $error("Link word written into a full receive buffer");
         fail_count++;
      end

   // A lowered limit is reached one cycle later, through the clamp
   issued_in_limit: assert property (@(posedge clk) disable iff (!rst_n)
      issued_a <= $past(limit_a) && issued_b <= $past(limit_b))
      else begin
         $error("Issued credits exceed the limit");
         fail_count++;
      end

endmodule

bind credit_link_top credit_link_properties u_props (
   .clk(clk),
   .rst_n(rst_n),
   .req_a(u_link_arbiter.send_req_a),
   .req_b(u_link_arbiter.send_req_b),
   .grant_a(u_link_arbiter.send_grant_a),
   .grant_b(u_link_arbiter.send_grant_b),
   .rx_wr_a(u_rx_a.wr_en),
   .rx_wr_b(u_rx_b.wr_en),
   .rx_count_a(u_rx_a.count),
   .rx_count_b(u_rx_b.count),
   .issued_a(credit_issued_a),
   .issued_b(credit_issued_b),
   .limit_a(credit_limit_a),
   .limit_b(credit_limit_b)
);

`default_nettype wire

/* verif/tb_credit_link.sv */
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit link testbench
// Runs the steps of the pattern file on both ports. It checks
// every output word against a per-port order model and the
// status outputs against the expected values of each step
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_credit_link;

   localparam int RESET_CYCLES  = 8;
   localparam int SETTLE_CYCLES = 10;                      // Covers link latency and credit return

   typedef logic [credit_pkg::DATA_W-1:0] data_t;
   typedef logic [credit_pkg::CNT_W-1:0]  cnt_t;

   logic  clk;
   logic  rst_n;
   logic  in_a_valid;
   logic  in_a_ready;
   data_t in_a_data;
   logic  out_a_valid;
   logic  out_a_ready;
   data_t out_a_data;
   logic  sw_init_a;
   logic  dis_used_a;
   logic  dis_return_a;
   cnt_t  credit_limit_a;
   logic  used_err_a;
   logic  return_err_a;
   cnt_t  credit_issued_a;
   logic  in_b_valid;
   logic  in_b_ready;
   data_t in_b_data;
   logic  out_b_valid;
   logic  out_b_ready;
   data_t out_b_data;
   logic  sw_init_b;
   logic  dis_used_b;
   logic  dis_return_b;
   cnt_t  credit_limit_b;
   logic  used_err_b;
   logic  return_err_b;
   cnt_t  credit_issued_b;

   logic [47:0] steps [64];
   data_t       exp_a [$];                                 // Words owed by output A, oldest first
   data_t       exp_b [$];
   logic [15:0] lfsr;
   int          data_errors;
   int          status_errors;
   int          timeout_cycles;

   credit_link_top u_credit_link_top (.*);

   always #5 clk = ~clk;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus data and compare helpers
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};     // Taps 16 14 13 11
   endfunction

   function automatic data_t next_word();
      data_t word;
      word = '0;
      for (int i = 0; i < credit_pkg::DATA_W; i++) begin
         lfsr = lfsr_step(lfsr);
         word = {word[credit_pkg::DATA_W-2:0], lfsr[0]};
      end
      return word;
   endfunction

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act) begin
         $display("ERROR %0d ns %s expected %h actual %h", $time, name, exp, act);
         data_errors++;
      end
   endtask

   task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
      if (exp !== act) begin
         $display("ERROR %0d ns %s expected %0d actual %0d", $time, name, exp, act);
         status_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("ERROR %0d ns %s expected %b actual %b", $time, name, exp, act);
         status_errors++;
      end
   endtask

   // Accepted inputs join the model, and every output pop is compared with it
   always @(negedge clk) begin
      if (rst_n) begin
         if (in_a_valid && in_a_ready) begin
            exp_a.push_back(in_a_data);
         end
         if (in_b_valid && in_b_ready) begin
            exp_b.push_back(in_b_data);
         end
         if (out_a_valid && out_a_ready) begin
            if (exp_a.size() == 0) begin
               $display("Port A delivered a word at %0d ns that was never sent", $time);
               data_errors++;
            end else begin
               check_data("out_a_data", exp_a.pop_front(), out_a_data);
            end
         end
         if (out_b_valid && out_b_ready) begin
            if (exp_b.size() == 0) begin
               $display("Port B delivered a word at %0d ns that was never sent", $time);
               data_errors++;
            end else begin
               check_data("out_b_data", exp_b.pop_front(), out_b_data);
            end
         end
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Step execution
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic run_pushes(input int n_a, input int n_b);
      int   left_a;
      int   left_b;
      logic took_a;
      logic took_b;
      left_a     = n_a;
      left_b     = n_b;
      in_a_valid = (left_a > 0);
      in_b_valid = (left_b > 0);
      in_a_data  = next_word();
      in_b_data  = next_word();
      while (left_a > 0 || left_b > 0) begin
         @(negedge clk);
         took_a = in_a_valid && in_a_ready;
         took_b = in_b_valid && in_b_ready;
         @(posedge clk);
         #1;
         if (took_a) begin
            left_a--;
            in_a_valid = (left_a > 0);
            in_a_data  = next_word();
         end
         if (took_b) begin
            left_b--;
            in_b_valid = (left_b > 0);
            in_b_data  = next_word();
         end
      end
   endtask

   task automatic run_step(input logic [47:0] s);
      out_a_ready    = !s[28];
      out_b_ready    = !s[29];
      credit_limit_a = cnt_t'(s[27:24]);
      credit_limit_b = cnt_t'(s[23:20]);
      dis_used_a     = s[18];
      if (s[17:16] != 2'b00) begin
         sw_init_a = s[16];                                // One-cycle pulse
         sw_init_b = s[17];
         @(posedge clk);
         #1;
         sw_init_a = 1'b0;
         sw_init_b = 1'b0;
      end
      run_pushes(int'(s[47:40]), int'(s[39:32]));
      // A port that is not stalled must hand out every word it owes
      while ((!s[28] && exp_a.size() != 0) || (!s[29] && exp_b.size() != 0)) begin
         @(posedge clk);
      end
      repeat (SETTLE_CYCLES) @(posedge clk);
      @(negedge clk);
      check_count("credit_issued_a", cnt_t'(s[15:12]), credit_issued_a);
      check_count("credit_issued_b", cnt_t'(s[11:8]), credit_issued_b);
      check_flag("used_err_a", s[4], used_err_a);
      check_flag("used_err_b", s[5], used_err_b);
      check_flag("return_err_a", s[6], return_err_a);
      check_flag("return_err_b", s[7], return_err_b);
      check_flag("in_a_ready", s[0], in_a_ready);
      check_flag("in_b_ready", s[1], in_b_ready);
      @(posedge clk);
      #1;
   endtask

   initial begin
      int n_steps;
      int total;
      int assert_fails;
      clk            = 1'b0;
      rst_n          = 1'b0;
      in_a_valid     = 1'b0;
      in_a_data      = '0;
      out_a_ready    = 1'b1;
      sw_init_a      = 1'b0;
      dis_used_a     = 1'b0;
      dis_return_a   = 1'b0;
      credit_limit_a = cnt_t'(credit_pkg::MAX_CREDITS);
      in_b_valid     = 1'b0;
      in_b_data      = '0;
      out_b_ready    = 1'b1;
      sw_init_b      = 1'b0;
      dis_used_b     = 1'b0;
      dis_return_b   = 1'b0;
      credit_limit_b = cnt_t'(credit_pkg::MAX_CREDITS);
      lfsr           = 16'd54363;
      data_errors    = 0;
      status_errors  = 0;
      $readmemh("verif/credit_link_patterns.txt", steps);
      n_steps = int'(steps[0]);                            // First word holds the step count
      total   = 0;
      for (int i = 1; i <= n_steps; i++) begin
         total += int'(steps[i][47:40]) + int'(steps[i][39:32]);
      end
      timeout_cycles = 20 * total + 200;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 1; i <= n_steps; i++) begin
         run_step(steps[i]);
      end
      if (exp_a.size() != 0 || exp_b.size() != 0) begin
         $display("Words were still owed at the end: %0d on A, %0d on B", exp_a.size(),
                  exp_b.size());
         status_errors++;
      end
      assert_fails = u_credit_link_top.u_props.fail_count;
      $display("Errors: %0d data, %0d status, %0d assertion", data_errors, status_errors,
               assert_fails);
      if (data_errors + status_errors + assert_fails == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Watchdog sized from the number of pushed words
   initial begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout: the link stopped moving words before all steps were done");
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/credit_link_patterns.txt */
// Digits: push_a(2) push_b(2) stall(b0 A,b1 B) lim_a lim_b ctrl(b0 init A,b1 init B,b2 dis_used A)
// then expected issued_a issued_b flags(b0 used A,b1 used B,b2 ret A,b3 ret B) ready(b0 A,b1 B)
00000000000f // Number of steps
080804400003 // Free flow on both ports
060814404002 // Port A stalled, port B still drains
000004400003 // Port A released
030011401002 // Limit A of 1 under stall
020401400003 // Limit A of 1 while flowing
040014404003 // Fill the port A buffer
000012402013 // Limit lowered below the issued count
000002400053 // Drain returns more than is issued
080304410003 // Re-init A, full limit again
040014444003 // Fill port A with used error masked
000012442003 // Lowered limit, flag stays low
000004440043 // Drain port A
050504430003 // Re-init both ports
050624400401 // Port B stalled, port A still drains
000004400003 // Port B released

/* verilog.f */
hw/credit_pkg.sv
hw/credit_manager.sv
hw/credit_sender.sv
hw/link_arbiter.sv
hw/rx_buffer.sv
hw/credit_link_top.sv
verif/credit_link_properties.sv
verif/tb_credit_link.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the credit link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_credit_link -o sim_credit_link

# Assertion errors are counted by the testbench instead of stopping the run
sim_out=$(./obj_dir/sim_credit_link +verilator+error+limit+1000)
echo "$sim_out"

echo "$sim_out" | grep -Fqx '>>> PASS'
